//--- design/axis_uart_pkg.sv
/*
 * UART shared definitions
 * Character and divider widths, FIFO depth, FSM state types and the
 * frame parity rule used by both the receiver and the transmitter.
 */
package axis_uart_pkg;

    localparam int DATA_WIDTH      = 8;
    localparam int DIVIDER_WIDTH   = 16;
    localparam int FIFO_DEPTH      = 8;
    localparam int BIT_CNT_WIDTH   = $clog2(DATA_WIDTH);
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_WAIT
    } uart_rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } uart_tx_state_e;

    // odd parity makes data plus parity carry an odd number of ones
    function automatic logic parity(input logic [DATA_WIDTH-1:0] data,
                                    input logic                  odd_sel,
                                    input logic                  even_sel);
        if (odd_sel) begin
            return ~^data;
        end else if (even_sel) begin
            return ^data;
        end
        return 1'b0;
    endfunction

endpackage

//--- design/axis_if.sv
/*
 * Byte stream interface
 * Data, valid and ready with the shared clock and reset.
 */
interface axis_if
    import axis_uart_pkg::*;
(
    input logic m_axis,
    input logic reset_i
);

    logic [DATA_WIDTH-1:0] tdata;
    logic                  tvalid;
    logic                  tready;

    modport master (input m_axis, input reset_i, input tready, output tdata, output tvalid);
    modport slave  (input m_axis, input reset_i, input tdata, input tvalid, output tready);

    // once offered, a word stays offered until it is taken
    a_tvalid_held: assert property (@(posedge m_axis) disable iff (reset_i)
        tvalid && !tready |=> tvalid);

endinterface

//--- design/axis_uart_fifo.sv
/*
 * Byte FIFO
 * Synchronous FIFO between a slave stream and a master stream, with
 * wrap-bit pointers giving full and empty.
 */
module axis_uart_fifo
    import axis_uart_pkg::*;
(
    input  logic   m_axis,
    input  logic   reset_i,
    axis_if.slave  wr_stream_i,
    axis_if.master rd_stream_o
);

logic [DATA_WIDTH-1:0]    mem [FIFO_DEPTH];
logic [FIFO_ADDR_WIDTH:0] wr_ptr;
logic [FIFO_ADDR_WIDTH:0] rd_ptr;
logic                     full;
logic                     empty;
logic                     wr_en;
logic                     rd_en;

always_ff @(posedge m_axis) begin
    if (wr_en) begin
        mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= wr_stream_i.tdata;
    end
end

always_ff @(posedge m_axis) begin
    if (reset_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
    end else begin
        if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end
end

// same address with different wrap bits means the write side lapped the read side
assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
               (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);
assign empty = (wr_ptr == rd_ptr);

assign wr_stream_i.tready = !full;
assign rd_stream_o.tvalid = !empty;
assign rd_stream_o.tdata  = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

assign wr_en = wr_stream_i.tvalid && wr_stream_i.tready;
assign rd_en = rd_stream_o.tvalid && rd_stream_o.tready;

// a write taken while full would push the fill level past the depth
a_no_write_when_full: assert property (@(posedge m_axis) disable iff (reset_i)
    (FIFO_ADDR_WIDTH + 1)'(wr_ptr - rd_ptr) <= FIFO_DEPTH);

endmodule

//--- design/axis_uart_rx.sv
/*
 * UART receiver
 * Samples the serial line at mid-bit, checks optional parity and
 * offers each good byte on a valid/ready stream.
 */
module axis_uart_rx
    import axis_uart_pkg::*;
(
    input  logic                     m_axis,
    input  logic                     reset_i,
    input  logic [DIVIDER_WIDTH-1:0] clk_divider_i,
    input  logic                     parity_odd_i,
    input  logic                     parity_even_i,
    input  logic                     uart_rx_i,
    axis_if.master                   stream_o
);

uart_rx_state_e state;

logic                     rx_meta;
logic                     rx_sync;
logic [BIT_CNT_WIDTH-1:0] bit_cnt;
logic [DIVIDER_WIDTH-1:0] baud_cnt;
logic [DATA_WIDTH-1:0]    rx_shift;
logic                     baud_en;
logic                     baud_done;
logic                     start_check;
logic                     bit_done;
logic                     parity_err;
logic                     load_word;
logic                     handshake;

// two-flop synchronizer reset to the idle high level
always_ff @(posedge m_axis) begin
    if (reset_i) begin
        rx_meta <= 1'b1;
        rx_sync <= 1'b1;
    end else begin
        rx_meta <= uart_rx_i;
        rx_sync <= rx_meta;
    end
end

always_ff @(posedge m_axis) begin
    if (reset_i) begin
        state      <= RX_IDLE;
        bit_cnt    <= '0;
        parity_err <= 1'b0;
        baud_en    <= 1'b0;
    end else begin
        case (state)
            RX_IDLE: begin
                parity_err <= 1'b0;
                bit_cnt    <= '0;
                if (!rx_sync) begin
                    state   <= RX_START;
                    baud_en <= 1'b1;
                end
            end
            RX_START: begin
                // a start bit gone high by its midpoint was a glitch
                if (start_check) begin
                    if (!rx_sync) begin
                        state <= RX_DATA;
                    end else begin
                        state   <= RX_IDLE;
                        baud_en <= 1'b0;
                    end
                end
            end
            RX_DATA: begin
                if (baud_done) begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (parity_odd_i || parity_even_i) begin
                            state <= RX_PARITY;
                        end else begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
            RX_PARITY: begin
                if (baud_done) begin
                    state      <= RX_STOP;
                    parity_err <= (parity(rx_shift, parity_odd_i, parity_even_i) != rx_sync);
                end
            end
            RX_STOP: begin
                if (baud_done) begin
                    state   <= RX_WAIT;
                    baud_en <= 1'b0;
                end
            end
            RX_WAIT: begin
                state <= RX_IDLE;
            end
            default: state <= RX_IDLE;
        endcase
    end
end

// data arrives lsb first, so shift in from the top
always_ff @(posedge m_axis) begin
    if ((state == RX_DATA) && baud_done) begin
        rx_shift <= {rx_sync, rx_shift[DATA_WIDTH-1:1]};
    end
end

always_ff @(posedge m_axis) begin
    if (reset_i || !baud_en || baud_done || start_check) begin
        baud_cnt <= '0;
    end else begin
        baud_cnt <= baud_cnt + 1'b1;
    end
end

always_ff @(posedge m_axis) begin
    if (reset_i) begin
        stream_o.tvalid <= 1'b0;
    end else if (load_word) begin
        stream_o.tvalid <= 1'b1;
    end else if (handshake) begin
        stream_o.tvalid <= 1'b0;
    end
end

always_ff @(posedge m_axis) begin
    if (load_word) begin
        stream_o.tdata <= rx_shift;
    end
end

assign baud_done   = baud_en && (baud_cnt == clk_divider_i - DIVIDER_WIDTH'(1));
assign start_check = (state == RX_START) &&
                     (baud_cnt == (clk_divider_i >> 1) - DIVIDER_WIDTH'(1));
assign bit_done    = (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));
assign handshake   = stream_o.tvalid && stream_o.tready;

// a byte still waiting in the output register wins and the new frame is dropped
assign load_word = (state == RX_WAIT) && !parity_err && (!stream_o.tvalid || stream_o.tready);

a_tdata_stable: assert property (@(posedge m_axis) disable iff (reset_i)
    stream_o.tvalid && !stream_o.tready |=> $stable(stream_o.tdata));

endmodule

//--- design/axis_uart_tx.sv
/*
 * UART transmitter
 * Takes one byte per frame from the stream and drives start, data,
 * optional parity and stop bits on a registered serial output.
 */
module axis_uart_tx
    import axis_uart_pkg::*;
(
    input  logic                     m_axis,
    input  logic                     reset_i,
    input  logic [DIVIDER_WIDTH-1:0] clk_divider_i,
    input  logic                     parity_odd_i,
    input  logic                     parity_even_i,
    axis_if.slave                    stream_i,
    output logic                     uart_tx_o
);

uart_tx_state_e state;

logic [BIT_CNT_WIDTH-1:0] bit_cnt;
logic [DIVIDER_WIDTH-1:0] baud_cnt;
logic [DATA_WIDTH-1:0]    tx_shift;
logic                     parity_bit;
logic                     baud_done;
logic                     bit_done;
logic                     handshake;

always_ff @(posedge m_axis) begin
    if (reset_i) begin
        state     <= TX_IDLE;
        bit_cnt   <= '0;
        uart_tx_o <= 1'b1;
    end else begin
        case (state)
            TX_IDLE: begin
                bit_cnt <= '0;
                if (handshake) begin
                    state     <= TX_START;
                    uart_tx_o <= 1'b0;
                end
            end
            TX_START: begin
                if (baud_done) begin
                    state     <= TX_DATA;
                    uart_tx_o <= tx_shift[0];
                end
            end
            TX_DATA: begin
                if (baud_done) begin
                    if (bit_done) begin
                        if (parity_odd_i || parity_even_i) begin
                            state     <= TX_PARITY;
                            uart_tx_o <= parity_bit;
                        end else begin
                            state     <= TX_STOP;
                            uart_tx_o <= 1'b1;
                        end
                    end else begin
                        bit_cnt   <= bit_cnt + 1'b1;
                        uart_tx_o <= tx_shift[0];
                    end
                end
            end
            TX_PARITY: begin
                if (baud_done) begin
                    state     <= TX_STOP;
                    uart_tx_o <= 1'b1;
                end
            end
            TX_STOP: begin
                if (baud_done) begin
                    state <= TX_IDLE;
                end
            end
            default: state <= TX_IDLE;
        endcase
    end
end

// tx_shift[0] always holds the next data bit to put on the line
always_ff @(posedge m_axis) begin
    if (handshake) begin
        tx_shift   <= stream_i.tdata;
        parity_bit <= parity(stream_i.tdata, parity_odd_i, parity_even_i);
    end else if (baud_done && ((state == TX_START) || (state == TX_DATA))) begin
        tx_shift <= tx_shift >> 1;
    end
end

always_ff @(posedge m_axis) begin
    if (reset_i || (state == TX_IDLE) || baud_done) begin
        baud_cnt <= '0;
    end else begin
        baud_cnt <= baud_cnt + 1'b1;
    end
end

assign stream_i.tready = (state == TX_IDLE);
assign handshake       = stream_i.tvalid && stream_i.tready;
assign baud_done       = (state != TX_IDLE) && (baud_cnt == clk_divider_i - DIVIDER_WIDTH'(1));
assign bit_done        = (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));

a_idle_line_high: assert property (@(posedge m_axis) disable iff (reset_i)
    (state == TX_IDLE) |-> uart_tx_o);

endmodule

//--- design/axis_uart_top.sv
/*
 * UART peripheral top level
 * Transmit FIFO and transmitter, receiver and receive FIFO, with plain
 * stream ports, serial pins and shared frame configuration.
 */
module axis_uart_top
    import axis_uart_pkg::*;
(
    input  logic                     m_axis,
    input  logic                     reset_i,
    input  logic [DIVIDER_WIDTH-1:0] clk_divider_i,
    input  logic                     parity_odd_i,
    input  logic                     parity_even_i,
    input  logic [DATA_WIDTH-1:0]    tx_tdata_i,
    input  logic                     tx_tvalid_i,
    output logic                     tx_tready_o,
    output logic [DATA_WIDTH-1:0]    rx_tdata_o,
    output logic                     rx_tvalid_o,
    input  logic                     rx_tready_i,
    input  logic                     uart_rx_i,
    output logic                     uart_tx_o
);

axis_if tx_host (.m_axis(m_axis), .reset_i(reset_i));
axis_if tx_in   (.m_axis(m_axis), .reset_i(reset_i));
axis_if rx_out  (.m_axis(m_axis), .reset_i(reset_i));
axis_if rx_host (.m_axis(m_axis), .reset_i(reset_i));

// host side of the transmit path
assign tx_host.tdata  = tx_tdata_i;
assign tx_host.tvalid = tx_tvalid_i;
assign tx_tready_o    = tx_host.tready;

// host side of the receive path
assign rx_tdata_o     = rx_host.tdata;
assign rx_tvalid_o    = rx_host.tvalid;
assign rx_host.tready = rx_tready_i;

axis_uart_fifo i_tx_fifo (
    .m_axis      (m_axis),
    .reset_i     (reset_i),
    .wr_stream_i (tx_host),
    .rd_stream_o (tx_in)
);

axis_uart_tx i_tx (
    .m_axis        (m_axis),
    .reset_i       (reset_i),
    .clk_divider_i (clk_divider_i),
    .parity_odd_i  (parity_odd_i),
    .parity_even_i (parity_even_i),
    .stream_i      (tx_in),
    .uart_tx_o     (uart_tx_o)
);

axis_uart_rx i_rx (
    .m_axis        (m_axis),
    .reset_i       (reset_i),
    .clk_divider_i (clk_divider_i),
    .parity_odd_i  (parity_odd_i),
    .parity_even_i (parity_even_i),
    .uart_rx_i     (uart_rx_i),
    .stream_o      (rx_out)
);

axis_uart_fifo i_rx_fifo (
    .m_axis      (m_axis),
    .reset_i     (reset_i),
    .wr_stream_i (rx_out),
    .rd_stream_o (rx_host)
);

endmodule

//--- test/axis_uart_tb.sv
/*
 * UART peripheral testbench
 * Runs transmit, receive, parity, glitch and back-pressure items from
 * a vector file against the top level and checks the results.
 */
module axis_uart_tb
    import axis_uart_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int CLK_PERIOD     = 40;
localparam int DRIVE_DELAY    = 2;
localparam int TIMEOUT_MARGIN = 200;

logic                     m_axis;
logic                     reset_i;
logic [DIVIDER_WIDTH-1:0] clk_divider_i;
logic                     parity_odd_i;
logic                     parity_even_i;
logic [DATA_WIDTH-1:0]    tx_tdata_i;
logic                     tx_tvalid_i;
logic                     tx_tready_o;
logic [DATA_WIDTH-1:0]    rx_tdata_o;
logic                     rx_tvalid_o;
logic                     rx_tready_i;
logic                     uart_rx_i;
logic                     uart_tx_o;

// one entry per vector line
logic [7:0]            vec_mode [$];
int                    vec_div  [$];
int                    vec_par  [$];
logic [DATA_WIDTH-1:0] vec_data [$];
int                    vec_bad  [$];

logic [DATA_WIDTH-1:0] expected_q [$];
logic [DATA_WIDTH-1:0] exp_byte;
logic [DATA_WIDTH-1:0] prev_data;
logic                  prev_stall;
logic [11:0]           frame;
int                    frame_len;
int                    seed        = 32'h7903;
int                    cycle_cnt   = 0;
int                    cycle_limit = 0;
int                    total       = 0;
int                    max_div     = 1;

axis_uart_top i_dut (
    .m_axis        (m_axis),
    .reset_i       (reset_i),
    .clk_divider_i (clk_divider_i),
    .parity_odd_i  (parity_odd_i),
    .parity_even_i (parity_even_i),
    .tx_tdata_i    (tx_tdata_i),
    .tx_tvalid_i   (tx_tvalid_i),
    .tx_tready_o   (tx_tready_o),
    .rx_tdata_o    (rx_tdata_o),
    .rx_tvalid_o   (rx_tvalid_o),
    .rx_tready_i   (rx_tready_i),
    .uart_rx_i     (uart_rx_i),
    .uart_tx_o     (uart_tx_o)
);

initial begin
    m_axis = 1'b0;
    forever #(CLK_PERIOD / 2) m_axis = ~m_axis;
end

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "run aborted");
endtask

task automatic report_mismatch(input string msg);
    abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
endtask

task automatic next_cycle();
    @(posedge m_axis);
    #DRIVE_DELAY;
endtask

// start bit, data lsb first, optional parity, one stop bit
function automatic void build_frame(input logic [7:0] data, input int psel, input int bad,
                                    output logic [11:0] bits, output int nbits);
    int ones;
    ones  = $countones(data);
    bits  = '1;
    bits[0] = 1'b0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
        bits[i + 1] = data[i];
    end
    nbits = DATA_WIDTH + 1;
    if (psel != 0) begin
        // odd mode adds a one when the data count is even, even mode when it is odd
        bits[nbits] = (((ones % 2) == 0) == (psel == 1)) ^ (bad != 0);
        nbits++;
    end
    bits[nbits] = 1'b1;
    nbits++;
endfunction

task automatic read_vectors();
    int         fd;
    int         ch;
    int         n;
    logic [7:0] mode;
    int         div;
    int         psel;
    logic [7:0] data;
    int         bad;
    fd = $fopen("test/uart_input_vectors.txt", "r");
    if (fd == 0) begin
        abort_run("could not open the vector file test/uart_input_vectors.txt");
    end
    while (!$feof(fd)) begin
        n = $fscanf(fd, " %c", mode);
        if (n == 1 && mode == "#") begin
            ch = $fgetc(fd);
            while (ch != "\n" && ch != -1) begin
                ch = $fgetc(fd);
            end
        end else if (n == 1) begin
            n = $fscanf(fd, "%d %d %h %d", div, psel, data, bad);
            if (n != 4 || !(mode inside {"T", "R", "G", "B"})) begin
                abort_run("the vector file holds a line that cannot be read");
            end
            vec_mode.push_back(mode);
            vec_div.push_back(div);
            vec_par.push_back(psel);
            vec_data.push_back(data);
            vec_bad.push_back(bad);
        end
    end
    $fclose(fd);
endtask

task automatic drive_serial(input logic [11:0] bits, input int nbits, input int div);
    for (int k = 0; k < nbits; k++) begin
        uart_rx_i = bits[k];
        repeat (div) next_cycle();
    end
    // one idle bit before the next frame
    uart_rx_i = 1'b1;
    repeat (div) next_cycle();
endtask

task automatic drive_glitch(input int div);
    uart_rx_i = 1'b0;
    repeat (div / 4) next_cycle();
    uart_rx_i = 1'b1;
    repeat (2 * div) next_cycle();
endtask

task automatic send_tx_byte(input logic [7:0] data);
    tx_tdata_i  = data;
    tx_tvalid_i = 1'b1;
    @(negedge m_axis);
    while (!tx_tready_o) begin
        @(negedge m_axis);
    end
    next_cycle();
    tx_tvalid_i = 1'b0;
endtask

// every cycle of every bit is compared, so bit length is checked too
task automatic check_tx_frame(input logic [11:0] bits, input int nbits, input int div,
                              input logic [7:0] data);
    while (uart_tx_o) begin
        @(negedge m_axis);
    end
    for (int k = 0; k < nbits; k++) begin
        for (int c = 0; c < div; c++) begin
            assert (uart_tx_o === bits[k]) else report_mismatch($sformatf(
                "tx byte %h bit %0d cycle %0d is %b, expected %b",
                data, k, c, uart_tx_o, bits[k]));
            @(negedge m_axis);
        end
    end
    next_cycle();
endtask

task automatic run_burst(input logic [7:0] first, input int psel, input int div);
    logic [11:0] bits;
    int          nbits;
    logic [7:0]  data;
    int          stall;
    rx_tready_i = 1'b0;
    for (int n = 0; n < FIFO_DEPTH; n++) begin
        data = first + 8'(n * 29);
        build_frame(data, psel, 0, bits, nbits);
        expected_q.push_back(data);
        drive_serial(bits, nbits, div);
    end
    while (expected_q.size() != 0) begin
        rx_tready_i = 1'b1;
        next_cycle();
        stall = $unsigned($random(seed)) % 4;
        rx_tready_i = 1'b0;
        repeat (stall) next_cycle();
    end
    rx_tready_i = 1'b1;
endtask

// receive stream monitor sampled mid-cycle where outputs are settled
always @(negedge m_axis) begin
    if (reset_i) begin
        prev_stall = 1'b0;
    end else begin
        if (prev_stall) begin
            assert (rx_tvalid_o && rx_tdata_o === prev_data) else report_mismatch($sformatf(
                "rx word %h dropped or changed while stalled", prev_data));
        end
        if (rx_tvalid_o && rx_tready_i) begin
            assert (expected_q.size() != 0) else report_mismatch($sformatf(
                "unexpected rx word %h", rx_tdata_o));
            exp_byte = expected_q.pop_front();
            assert (rx_tdata_o === exp_byte) else report_mismatch($sformatf(
                "rx word %h, expected %h", rx_tdata_o, exp_byte));
        end
        prev_stall = rx_tvalid_o && !rx_tready_i;
        prev_data  = rx_tdata_o;
    end
end

always @(posedge m_axis) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
        abort_run($sformatf("the run timed out after %0d clock cycles", cycle_cnt));
    end
end

initial begin
    reset_i       = 1'b1;
    clk_divider_i = DIVIDER_WIDTH'(8);
    parity_odd_i  = 1'b0;
    parity_even_i = 1'b0;
    tx_tdata_i    = '0;
    tx_tvalid_i   = 1'b0;
    rx_tready_i   = 1'b1;
    uart_rx_i     = 1'b1;
    read_vectors();
    // about 12 bit periods per frame and FIFO_DEPTH frames per burst line
    foreach (vec_mode[i]) begin
        total   += 12 * vec_div[i] * ((vec_mode[i] == "B") ? FIFO_DEPTH : 1);
        max_div  = (vec_div[i] > max_div) ? vec_div[i] : max_div;
    end
    cycle_limit = total + total / 10 + TIMEOUT_MARGIN;
    repeat (2) @(posedge m_axis);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    @(negedge m_axis);
    assert (uart_tx_o === 1'b1 && tx_tready_o === 1'b1 && rx_tvalid_o === 1'b0)
        else report_mismatch("outputs after reset are not idle");
    next_cycle();
    foreach (vec_mode[i]) begin
        clk_divider_i = DIVIDER_WIDTH'(vec_div[i]);
        parity_odd_i  = (vec_par[i] == 1);
        parity_even_i = (vec_par[i] == 2);
        build_frame(vec_data[i], vec_par[i], vec_bad[i], frame, frame_len);
        case (vec_mode[i])
            "T": begin
                send_tx_byte(vec_data[i]);
                check_tx_frame(frame, frame_len, vec_div[i], vec_data[i]);
            end
            "R": begin
                if (vec_bad[i] == 0) begin
                    expected_q.push_back(vec_data[i]);
                end
                drive_serial(frame, frame_len, vec_div[i]);
            end
            "G": drive_glitch(vec_div[i]);
            "B": run_burst(vec_data[i], vec_par[i], vec_div[i]);
        endcase
    end
    while (expected_q.size() != 0) begin
        next_cycle();
    end
    repeat (2 * max_div) next_cycle();
    assert (rx_tvalid_o === 1'b0) else report_mismatch("rx stream holds a word after the last item");
    $display("No errors");
    $finish;
end

endmodule

//--- test/uart_input_vectors.txt
# mode divider parity byte corrupt : parity 0 none, 1 odd, 2 even; byte in hex
# modes: T transmit, R receive frame, G start glitch, B burst under back-pressure
T 8 0 a5 0
T 16 1 3c 0
T 8 2 81 0
T 16 2 00 0
R 8 0 5a 0
R 16 0 c3 0
R 8 1 7e 0
R 16 1 01 0
R 8 2 ff 0
R 16 2 96 0
R 8 1 44 1
R 8 1 45 0
R 16 2 12 1
R 16 2 34 0
G 8 0 00 0
R 8 0 e7 0
G 16 2 00 0
R 16 2 29 0
B 8 1 10 0
B 16 0 f0 0

//--- sources.f
design/axis_uart_pkg.sv
design/axis_if.sv
design/axis_uart_fifo.sv
design/axis_uart_rx.sv
design/axis_uart_tx.sv
design/axis_uart_top.sv
test/axis_uart_tb.sv

//--- Bender.yml
package:
  name: axis_uart

sources:
  - design/axis_uart_pkg.sv
  - design/axis_if.sv
  - design/axis_uart_fifo.sv
  - design/axis_uart_rx.sv
  - design/axis_uart_tx.sv
  - design/axis_uart_top.sv
  - target: test
    files:
      - test/axis_uart_tb.sv
